/* Bender.yml */
package:
  name: mul_div_unit

sources:
  - logic/mipsInstrPkg.sv
  - logic/mulDivPkg.sv
  - logic/mdDecode.sv
  - logic/mulDivCore.sv
  - logic/hiLoRegs.sv
  - logic/mulDivUnit.sv
  - target: simulation
    files:
      - bench/mulDivUnitTb.sv

/* bench/mulDivGolden.txt */
# Columns in hex: instruction word, rs, rt, check flag, expected out.
# Flag 1 checks out in the same cycle, flag 2 presents the word while busy.
test reset_moves
00001010 00000000 00000000 1 00000000
00001812 00000000 00000000 1 00000000
00800011 12345678 00000000 0 00000000
00800013 9abcdef0 00000000 0 00000000
00001010 00000000 00000000 1 12345678
00001812 00000000 00000000 1 9abcdef0
test multiply
00850018 fffffffe 00000003 0 00000000
00001010 00000000 00000000 1 ffffffff
00001812 00000000 00000000 1 fffffffa
00850019 fffffffe 00000003 0 00000000
00001010 00000000 00000000 1 00000002
00001812 00000000 00000000 1 fffffffa
00850018 80000000 80000000 0 00000000
00001010 00000000 00000000 1 40000000
00001812 00000000 00000000 1 00000000
test divide
0085001a fffffff9 00000002 0 00000000
00001010 00000000 00000000 1 ffffffff
00001812 00000000 00000000 1 fffffffd
0085001b fffffff9 00000002 0 00000000
00001010 00000000 00000000 1 00000001
00001812 00000000 00000000 1 7ffffffc
0085001a 00001234 00000000 0 00000000
00001010 00000000 00000000 1 00001234
00001812 00000000 00000000 1 ffffffff
0085001b 87654321 00000000 0 00000000
00001010 00000000 00000000 1 87654321
00001812 00000000 00000000 1 ffffffff
0085001a 80000000 ffffffff 0 00000000
00001010 00000000 00000000 1 00000000
00001812 00000000 00000000 1 80000000
test accumulate
00800011 00000000 00000000 0 00000000
00800013 ffffffff 00000000 0 00000000
70850001 00000001 00000001 0 00000000
00001010 00000000 00000000 1 00000001
00001812 00000000 00000000 1 00000000
70850000 ffffffff 00000002 0 00000000
00001010 00000000 00000000 1 00000000
00001812 00000000 00000000 1 fffffffe
70850004 fffffffd 00000001 0 00000000
00001010 00000000 00000000 1 00000001
00001812 00000000 00000000 1 00000001
70850005 00000002 00000001 0 00000000
00001010 00000000 00000000 1 00000000
00001812 00000000 00000000 1 ffffffff
test busy_block
00800013 0000aaaa 00000000 0 00000000
00850018 00000003 00000004 0 00000000
00800013 deadbeef 00000000 2 00000000
00001812 00000000 00000000 2 00000000
00001812 00000000 00000000 1 0000000c

/* bench/mulDivUnitTb.sv */
`timescale 1ns/1ps

module mulDivUnitTb;
    import mipsInstrPkg::*;

    localparam int MULT_LATENCY = 5;
    localparam int DIV_LATENCY = 10;
    localparam int RESET_CYCLES = 16;

    logic clk;
    logic reset;
    logic [31:0] instr;
    logic [31:0] dataRs;
    logic [31:0] dataRt;
    logic busy;
    logic [31:0] out;

    logic [31:0] vInstr[$];
    logic [31:0] vRs[$];
    logic [31:0] vRt[$];
    logic [31:0] vFlag[$];
    logic [31:0] vExp[$];
    int vTest[$];
    string testNames[$];

    int errorCount = 0;
    int testErrors = 0;
    int passedTests = 0;
    int failedTests = 0;
    int cycleCount = 0;
    int limitCycles = 0;
    int pendingLat = 0;    // Latency of the long op in flight or zero if there is none.
    int busyCount = 0;
    logic lastBusy = 1'b0;

    mulDivUnit #(
        .MULT_LATENCY(MULT_LATENCY),
        .DIV_LATENCY(DIV_LATENCY)
    ) dut0 (
        .clk(clk),
        .reset(reset),
        .instr(instr),
        .dataRs(dataRs),
        .dataRt(dataRt),
        .busy(busy),
        .out(out)
    );

    always #50 clk = ~clk;

    always @(posedge clk) begin
        cycleCount++;
        if (limitCycles > 0 && cycleCount > limitCycles) begin
            $display("Timeout: the run went past %0d clock cycles.", limitCycles);
            $display("Simulation failed");
            $finish;
        end
    end

    task automatic checkValue(input logic [31:0] actual, input logic [31:0] expected,
                              input string what);
        if (actual !== expected) begin
            $display("MISMATCH at %0t: %s, got %h, expected %h", $time, what, actual, expected);
            errorCount++;
            testErrors++;
        end
    endtask

    // Busy cycles that an instruction costs, taken from its encoding.
    function automatic int latencyOf(input instrWord w);
        int lat;
        lat = 0;
        if (w.opcode == OPC_SPECIAL) begin
            if (w.funct == FN_MULT || w.funct == FN_MULTU) begin
                lat = MULT_LATENCY;
            end else if (w.funct == FN_DIV || w.funct == FN_DIVU) begin
                lat = DIV_LATENCY;
            end
        end else if (w.opcode == OPC_SPECIAL2) begin
            if (w.funct == FN_MADD || w.funct == FN_MADDU || w.funct == FN_MSUB ||
                w.funct == FN_MSUBU) begin
                lat = MULT_LATENCY;
            end
        end
        return lat;
    endfunction

    task automatic readGolden(output bit ok);
        int fd;
        int code;
        string line;
        string name;
        logic [31:0] f0;
        logic [31:0] f1;
        logic [31:0] f2;
        logic [31:0] f3;
        logic [31:0] f4;
        ok = 1'b0;
        fd = $fopen("bench/mulDivGolden.txt", "r");
        if (fd != 0) begin
            ok = 1'b1;
            while (!$feof(fd)) begin
                code = $fgets(line, fd);
                if (code > 0 && line.substr(0, 0) != "#") begin
                    if ($sscanf(line, "test %s", name) == 1) begin
                        testNames.push_back(name);
                    end else if ($sscanf(line, "%h %h %h %h %h", f0, f1, f2, f3, f4) == 5) begin
                        vInstr.push_back(f0);
                        vRs.push_back(f1);
                        vRt.push_back(f2);
                        vFlag.push_back(f3);
                        vExp.push_back(f4);
                        vTest.push_back(testNames.size() - 1);
                    end
                end
            end
            $fclose(fd);
        end
    endtask

    // Drives one word a little after the edge and returns at the following falling edge.
    task automatic present(input logic [31:0] word, input logic [31:0] rs, input logic [31:0] rt);
        @(posedge clk);
        #5;
        instr = word;
        dataRs = rs;
        dataRt = rt;
        @(negedge clk);
    endtask

    task automatic closeLongOp();
        if (pendingLat != 0) begin
            while (lastBusy) begin
                present(32'h0, 32'h0, 32'h0);
                if (busy) begin
                    busyCount++;
                end
                lastBusy = busy;
            end
            checkValue(busyCount, pendingLat + 1, "busy cycles of long operation");
            pendingLat = 0;
            busyCount = 0;
        end
    endtask

    task automatic runVector(input int i);
        int lat;
        lat = latencyOf(vInstr[i]);
        present(vInstr[i], vRs[i], vRt[i]);
        if (vFlag[i] == 2) begin
            checkValue(busy, 1'b1, $sformatf("vector %0d busy while blocked", i));
            checkValue(out, vExp[i], $sformatf("vector %0d out while busy", i));
            if (busy) begin
                busyCount++;
            end
            lastBusy = busy;
        end else begin
            if (lat != 0) begin
                checkValue(busy, 1'b1, $sformatf("vector %0d busy on issue", i));
                busyCount = busy ? 1 : 0;
                pendingLat = lat;
                lastBusy = busy;
            end else begin
                checkValue(busy, 1'b0, $sformatf("vector %0d busy on short op", i));
            end
            if (vFlag[i] == 1) begin
                checkValue(out, vExp[i], $sformatf("vector %0d out", i));
            end
        end
    endtask

    task automatic reportTest(input int t);
        if (testErrors == 0) begin
            passedTests++;
            $display("Test %s: passed", testNames[t]);
        end else begin
            failedTests++;
            $display("Test %s: failed with %0d errors", testNames[t], testErrors);
        end
        testErrors = 0;
    endtask

    initial begin
        bit ok;
        clk = 1'b0;
        reset = 1'b1;
        instr = '0;
        dataRs = '0;
        dataRt = '0;
        readGolden(ok);
        if (!ok || vInstr.size() == 0) begin
            $display("The golden file bench/mulDivGolden.txt could not be read.");
            $display("Simulation failed");
            $finish;
        end else begin
            limitCycles = vInstr.size() * (DIV_LATENCY + 4) + RESET_CYCLES;
            repeat (RESET_CYCLES) @(posedge clk);
            #5;
            reset = 1'b0;
            for (int i = 0; i < vInstr.size(); i++) begin
                if (i > 0 && vTest[i] != vTest[i-1]) begin
                    closeLongOp();
                    reportTest(vTest[i-1]);
                end
                if (vFlag[i] != 2) begin
                    closeLongOp();
                end
                runVector(i);
            end
            closeLongOp();
            reportTest(vTest[vInstr.size()-1]);
            $display("Tests passed: %0d, tests failed: %0d", passedTests, failedTests);
            if (errorCount == 0 && failedTests == 0) begin
                $display("Simulation completed successfully");
            end else begin
                $display("Simulation failed");
            end
            $finish;
        end
    end

endmodule

/* logic/hiLoRegs.sv */
`timescale 1ns/1ps

module hiLoRegs (
    input logic clk,
    input logic reset,
    input mulDivPkg::hiLoWrite wr,
    input mulDivPkg::mdCmd cmd,
    input logic busy,
    output logic [63:0] hiLo,
    output logic [31:0] out
);
    import mulDivPkg::*;

    logic [31:0] hi;
    logic [31:0] lo;

    always_ff @(posedge clk) begin
        if (reset) begin
            hi <= '0;
            lo <= '0;
        end else begin
            if (wr.writeHi) begin
                hi <= wr.hi;
            end
            if (wr.writeLo) begin
                lo <= wr.lo;
            end
        end
    end

    assign hiLo = {hi, lo};

    // Reads are refused while a long operation is in flight.
    always_comb begin
        out = '0;
        if (!busy) begin
            case (cmd.op)
                MD_MFHI: out = hi;
                MD_MFLO: out = lo;
                default: out = '0;
            endcase
        end
    end

endmodule

/* logic/mdDecode.sv */
`timescale 1ns/1ps

module mdDecode (
    input mipsInstrPkg::instrWord instr,
    output mulDivPkg::mdCmd cmd
);
    import mipsInstrPkg::*;
    import mulDivPkg::*;

    always_comb begin
        cmd.op = MD_NOP;
        cmd.isUnsigned = 1'b0;
        case (instr.opcode)
            OPC_SPECIAL: begin
                case (instr.funct)
                    FN_MULT: begin
                        cmd.op = MD_MULT;
                    end
                    FN_MULTU: begin
                        cmd.op = MD_MULT;
                        cmd.isUnsigned = 1'b1;
                    end
                    FN_DIV: begin
                        cmd.op = MD_DIV;
                    end
                    FN_DIVU: begin
                        cmd.op = MD_DIV;
                        cmd.isUnsigned = 1'b1;
                    end
                    FN_MTHI: begin
                        cmd.op = MD_MTHI;
                    end
                    FN_MTLO: begin
                        cmd.op = MD_MTLO;
                    end
                    FN_MFHI: begin
                        cmd.op = MD_MFHI;
                    end
                    FN_MFLO: begin
                        cmd.op = MD_MFLO;
                    end
                    default: begin
                        cmd.op = MD_NOP;    // Other SPECIAL words belong to the ALU.
                    end
                endcase
            end
            OPC_SPECIAL2: begin
                case (instr.funct)
                    FN_MADD: begin
                        cmd.op = MD_MADD;
                    end
                    FN_MADDU: begin
                        cmd.op = MD_MADD;
                        cmd.isUnsigned = 1'b1;
                    end
                    FN_MSUB: begin
                        cmd.op = MD_MSUB;
                    end
                    FN_MSUBU: begin
                        cmd.op = MD_MSUB;
                        cmd.isUnsigned = 1'b1;
                    end
                    default: begin
                        cmd.op = MD_NOP;
                    end
                endcase
            end
            default: begin
                cmd.op = MD_NOP;
            end
        endcase
    end

endmodule

/* logic/mipsInstrPkg.sv */
package mipsInstrPkg;

    localparam int OPCODE_WIDTH = 6;
    localparam int REG_WIDTH = 5;
    localparam int FUNCT_WIDTH = 6;

    typedef logic [OPCODE_WIDTH-1:0] opcodeField;
    typedef logic [REG_WIDTH-1:0] regField;
    typedef logic [FUNCT_WIDTH-1:0] functField;

    // Primary opcodes that carry the multiply/divide group.
    localparam opcodeField OPC_SPECIAL = 6'b000000;
    localparam opcodeField OPC_SPECIAL2 = 6'b011100;

    // Function codes under SPECIAL.
    localparam functField FN_MFHI = 6'h10;
    localparam functField FN_MTHI = 6'h11;
    localparam functField FN_MFLO = 6'h12;
    localparam functField FN_MTLO = 6'h13;
    localparam functField FN_MULT = 6'h18;
    localparam functField FN_MULTU = 6'h19;
    localparam functField FN_DIV = 6'h1a;
    localparam functField FN_DIVU = 6'h1b;

    // Function codes under SPECIAL2.
    localparam functField FN_MADD = 6'h00;
    localparam functField FN_MADDU = 6'h01;
    localparam functField FN_MSUB = 6'h04;
    localparam functField FN_MSUBU = 6'h05;

    // R-type layout, most significant field first.
    typedef struct packed {
        opcodeField opcode;    // Bits 31 to 26.
        regField rs;           // Bits 25 to 21.
        regField rt;           // Bits 20 to 16.
        regField rd;           // Bits 15 to 11.
        regField shamt;        // Bits 10 to 6.
        functField funct;      // Bits 5 to 0.
    } instrWord;

endpackage

/* logic/mulDivCore.sv */
`timescale 1ns/1ps

module mulDivCore #(
    parameter logic [mulDivPkg::LAT_WIDTH-1:0] MULT_LATENCY = 5,
    parameter logic [mulDivPkg::LAT_WIDTH-1:0] DIV_LATENCY = 10
) (
    input logic clk,
    input logic reset,
    input mulDivPkg::mdCmd cmd,
    input logic [31:0] dataRs,
    input logic [31:0] dataRt,
    input logic [63:0] hiLo,
    output logic busy,
    output mulDivPkg::hiLoWrite wr
);
    import mulDivPkg::*;

    localparam logic [31:0] MOST_NEGATIVE = 32'h8000_0000;

    logic [LAT_WIDTH-1:0] count;
    logic [LAT_WIDTH-1:0] nextLatency;
    logic [63:0] pendingHiLo;
    logic [63:0] nextHiLo;
    logic [63:0] extRs;
    logic [63:0] extRt;
    logic [63:0] product;
    logic [31:0] quoSigned;
    logic [31:0] remSigned;
    logic [31:0] quoUnsigned;
    logic [31:0] remUnsigned;
    logic [31:0] quotient;
    logic [31:0] remainder;
    logic idle;
    logic accept;

    assign idle = (count == '0);
    assign accept = idle && isLongOp(cmd.op);
    assign busy = !idle || accept;    // Long op raises busy in the cycle it is presented.

    // Sign or zero extension lets one 64-bit multiplier serve both forms.
    assign extRs = cmd.isUnsigned ? {32'b0, dataRs} : {{32{dataRs[31]}}, dataRs};
    assign extRt = cmd.isUnsigned ? {32'b0, dataRt} : {{32{dataRt[31]}}, dataRt};
    assign product = extRs * extRt;

    assign quoSigned = $signed(dataRs) / $signed(dataRt);
    assign remSigned = $signed(dataRs) % $signed(dataRt);
    assign quoUnsigned = dataRs / dataRt;
    assign remUnsigned = dataRs % dataRt;

    always_comb begin
        if (dataRt == '0) begin
            quotient = '1;             // Division by zero gives all ones.
            remainder = dataRs;
        end else if (!cmd.isUnsigned && dataRs == MOST_NEGATIVE && dataRt == '1) begin
            quotient = dataRs;         // Overflow case keeps the dividend.
            remainder = '0;
        end else if (cmd.isUnsigned) begin
            quotient = quoUnsigned;
            remainder = remUnsigned;
        end else begin
            quotient = quoSigned;
            remainder = remSigned;
        end
    end

    always_comb begin
        nextLatency = MULT_LATENCY;
        case (cmd.op)
            MD_MULT: nextHiLo = product;
            MD_DIV: begin
                nextHiLo = {remainder, quotient};
                nextLatency = DIV_LATENCY;
            end
            MD_MADD: nextHiLo = hiLo + product;
            MD_MSUB: nextHiLo = hiLo - product;
            default: nextHiLo = hiLo;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            count <= '0;
        end else if (!idle) begin
            count <= count - 1'b1;
        end else if (accept) begin
            count <= nextLatency;
        end
    end

    // The result is fixed at acceptance and held until the last busy cycle.
    always_ff @(posedge clk) begin
        if (accept) begin
            pendingHiLo <= nextHiLo;
        end
    end

    always_comb begin
        wr.writeHi = (count == LAT_WIDTH'(1));
        wr.writeLo = (count == LAT_WIDTH'(1));
        wr.hi = pendingHiLo[63:32];
        wr.lo = pendingHiLo[31:0];
        if (idle) begin
            case (cmd.op)
                MD_MTHI: begin
                    wr.writeHi = 1'b1;
                    wr.hi = dataRs;
                end
                MD_MTLO: begin
                    wr.writeLo = 1'b1;
                    wr.lo = dataRs;
                end
                default: begin
                    wr.writeHi = 1'b0;
                    wr.writeLo = 1'b0;
                end
            endcase
        end
    end

endmodule

/* logic/mulDivPkg.sv */
package mulDivPkg;

    // Width of the latency counter and of the latency parameters.
    localparam int LAT_WIDTH = 5;

    // Signedness is carried separately so each operation has one code.
    typedef enum logic [3:0] {
        MD_NOP  = 4'd0,
        MD_MULT = 4'd1,
        MD_DIV  = 4'd2,
        MD_MADD = 4'd3,
        MD_MSUB = 4'd4,
        MD_MTHI = 4'd5,
        MD_MTLO = 4'd6,
        MD_MFHI = 4'd7,
        MD_MFLO = 4'd8
    } mdOp;

    typedef struct packed {
        mdOp op;
        logic isUnsigned;    // Set for the U forms only.
    } mdCmd;

    typedef struct packed {
        logic writeHi;
        logic writeLo;
        logic [31:0] hi;
        logic [31:0] lo;
    } hiLoWrite;

    // Operations that occupy the unit for a latency period.
    function automatic logic isLongOp(input mdOp op);
        return (op == MD_MULT) || (op == MD_DIV) || (op == MD_MADD) || (op == MD_MSUB);
    endfunction

endpackage

/* logic/mulDivUnit.sv */
`timescale 1ns/1ps

module mulDivUnit #(
    parameter logic [mulDivPkg::LAT_WIDTH-1:0] MULT_LATENCY = 5,
    parameter logic [mulDivPkg::LAT_WIDTH-1:0] DIV_LATENCY = 10
) (
    input logic clk,
    input logic reset,
    input logic [31:0] instr,
    input logic [31:0] dataRs,
    input logic [31:0] dataRt,
    output logic busy,
    output logic [31:0] out
);
    import mipsInstrPkg::*;
    import mulDivPkg::*;

    mdCmd cmd;
    hiLoWrite wr;
    logic [63:0] hiLo;

    mdDecode decode0 (
        .instr(instrWord'(instr)),
        .cmd(cmd)
    );

    mulDivCore #(
        .MULT_LATENCY(MULT_LATENCY),
        .DIV_LATENCY(DIV_LATENCY)
    ) core0 (
        .clk(clk),
        .reset(reset),
        .cmd(cmd),
        .dataRs(dataRs),
        .dataRt(dataRt),
        .hiLo(hiLo),
        .busy(busy),
        .wr(wr)
    );

    hiLoRegs regs0 (
        .clk(clk),
        .reset(reset),
        .wr(wr),
        .cmd(cmd),
        .busy(busy),
        .hiLo(hiLo),
        .out(out)
    );

endmodule

/* tb.f */
logic/mipsInstrPkg.sv
logic/mulDivPkg.sv
logic/mdDecode.sv
logic/mulDivCore.sv
logic/hiLoRegs.sv
logic/mulDivUnit.sv
bench/mulDivUnitTb.sv
